/* hw/fetch_pkg.sv */
package fetch_pkg;

    // address and data width of the core
    localparam int XLEN = 64;

    // width of one uncompressed instruction
    localparam int ILEN = 32;

    // pc step between sequential instructions
    localparam int ILEN_BYTES = ILEN / 8;

    // source of a pc redirect from the memory stage
    typedef enum logic [2:0] {
        rk_none   = 3'd0,
        rk_jal    = 3'd1,
        rk_branch = 3'd2,
        rk_jalr   = 3'd3,
        rk_trap   = 3'd4
    } redirect_kind_e;

    // read channel FSM of the fetch bus master
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_addr = 2'd1,
        st_data = 2'd2
    } bus_state_e;

endpackage

/* hw/branch_resolver.sv */
`timescale 1ns/10ps

module branch_resolver (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       mem_jal_i,
    input  logic                       mem_branch_i,
    input  logic                       mem_jalr_i,
    input  logic                       trap_i,
    input  logic [fetch_pkg::XLEN-1:0] mem_alu_res_i,
    input  logic [fetch_pkg::XLEN-1:0] mem_pc_i,
    input  logic [fetch_pkg::XLEN-1:0] mem_imm_i,
    input  logic [fetch_pkg::XLEN-1:0] mem_rs1_i,
    input  logic [fetch_pkg::XLEN-1:0] mtvec_i,
    output fetch_pkg::redirect_kind_e  redirect_kind,
    output logic [fetch_pkg::XLEN-1:0] redirect_target
);
    import fetch_pkg::*;

    logic           branch_taken;
    logic [XLEN-1:0] jalr_sum;
    redirect_kind_e kind_d;
    logic [XLEN-1:0] target_d;

    // branch compare result comes from the alu, zero means taken
    assign branch_taken = mem_branch_i && (mem_alu_res_i == '0);
    assign jalr_sum     = mem_rs1_i + mem_imm_i;

    // fixed priority: pc-relative jumps, then jalr, then trap
    always_comb begin
        kind_d   = rk_none;
        target_d = mem_pc_i + mem_imm_i;
        if (mem_jal_i) begin
            kind_d = rk_jal;
        end else if (branch_taken) begin
            kind_d = rk_branch;
        end else if (mem_jalr_i) begin
            kind_d   = rk_jalr;
            // jalr drops the lowest bit of the sum
            target_d = {jalr_sum[XLEN-1:1], 1'b0};
        end else if (trap_i) begin
            kind_d   = rk_trap;
            target_d = mtvec_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            redirect_kind <= rk_none;
        end else begin
            redirect_kind <= kind_d;
        end
    end

    // target only matters while the kind is not none
    always_ff @(posedge clk) begin
        redirect_target <= target_d;
    end

endmodule

/* hw/fetch_bus_master.sv */
`timescale 1ns/10ps

module fetch_bus_master (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       req_valid,
    input  logic [fetch_pkg::XLEN-1:0] req_addr,
    input  logic                       req_epoch,
    output logic                       bus_idle,
    output logic                       rsp_valid,
    output logic [fetch_pkg::XLEN-1:0] rsp_data,
    output logic                       rsp_epoch,
    output logic                       ar_valid_o,
    input  logic                       ar_ready_i,
    output logic [fetch_pkg::XLEN-1:0] ar_addr_o,
    input  logic                       r_valid_i,
    output logic                       r_ready_o,
    input  logic [fetch_pkg::XLEN-1:0] r_data_i
);
    import fetch_pkg::*;

    bus_state_e state_q;
    bus_state_e state_d;
    logic       epoch_q;
    logic       req_fire;
    logic       data_fire;

    // handshake strobes
    assign req_fire  = (state_q == st_idle) && req_valid;
    assign data_fire = (state_q == st_data) && r_valid_i;

    // one read at a time: request, address phase, data phase
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (req_valid) begin
                    state_d = st_addr;
                end
            end
            st_addr: begin
                if (ar_ready_i) begin
                    state_d = st_data;
                end
            end
            st_data: begin
                if (r_valid_i) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q   <= st_idle;
            rsp_valid <= 1'b0;
        end else begin
            state_q   <= state_d;
            rsp_valid <= data_fire;
        end
    end

    // address and epoch are captured with the request and held
    // until the address phase completes
    always_ff @(posedge clk) begin
        if (req_fire) begin
            ar_addr_o <= req_addr;
            epoch_q   <= req_epoch;
        end
    end

    // returned word travels with the epoch of its request
    always_ff @(posedge clk) begin
        if (data_fire) begin
            rsp_data  <= r_data_i;
            rsp_epoch <= epoch_q;
        end
    end

    assign bus_idle   = (state_q == st_idle);
    assign ar_valid_o = (state_q == st_addr);
    assign r_ready_o  = (state_q == st_data);

endmodule

/* hw/fetch_control.sv */
`timescale 1ns/10ps

module fetch_control #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC = 64'h8000_0000
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  fetch_pkg::redirect_kind_e  redirect_kind,
    input  logic [fetch_pkg::XLEN-1:0] redirect_target,
    input  logic                       bus_idle,
    input  logic                       rsp_valid,
    input  logic                       rsp_epoch,
    input  logic [fetch_pkg::XLEN-1:0] rsp_data,
    output logic                       req_valid,
    output logic [fetch_pkg::XLEN-1:0] req_addr,
    output logic                       req_epoch,
    input  logic                       stall_i,
    output logic                       inst_valid_o,
    output logic [fetch_pkg::ILEN-1:0] inst_o,
    output logic [fetch_pkg::XLEN-1:0] pc_o,
    input  logic                       inst_ready_i
);
    import fetch_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic            epoch_q;
    logic [XLEN-1:0] inflight_addr_q;
    logic            redirect;
    logic            rsp_hit;
    logic            slot_free;
    logic [ILEN-1:0] inst_sel;

    assign redirect = (redirect_kind != rk_none);

    // stale responses carry the old epoch and are dropped
    assign rsp_hit = rsp_valid && (rsp_epoch == epoch_q);

    // slot is empty now or drains at this edge
    assign slot_free = !inst_valid_o || inst_ready_i;

    // the only thing that fills the slot is our own response, so a
    // request goes out only when that response will find room
    assign req_valid = bus_idle && !stall_i && !redirect && !rsp_valid && slot_free;
    assign req_addr  = pc_q;
    assign req_epoch = epoch_q;

    // bit 2 picks the 32-bit half of the 8-byte word
    assign inst_sel = inflight_addr_q[2] ? rsp_data[XLEN-1:ILEN] : rsp_data[ILEN-1:0];

    // pc and epoch
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q    <= RESET_PC;
            epoch_q <= 1'b0;
        end else if (redirect) begin
            pc_q    <= redirect_target;
            epoch_q <= !epoch_q;
        end else if (req_valid) begin
            pc_q <= pc_q + XLEN'(ILEN_BYTES);
        end
    end

    // address of the read on the bus, used for half selection and pc_o
    always_ff @(posedge clk) begin
        if (req_valid) begin
            inflight_addr_q <= pc_q;
        end
    end

    // output slot valid, a redirect kills whatever sits there
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            inst_valid_o <= 1'b0;
        end else if (redirect) begin
            inst_valid_o <= 1'b0;
        end else if (rsp_hit) begin
            inst_valid_o <= 1'b1;
        end else if (inst_ready_i) begin
            inst_valid_o <= 1'b0;
        end
    end

    // slot payload, loaded only when a response lands
    always_ff @(posedge clk) begin
        if (rsp_hit) begin
            inst_o <= inst_sel;
            pc_o   <= inflight_addr_q;
        end
    end

endmodule

/* hw/fetch_top.sv */
`timescale 1ns/10ps

module fetch_top #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC = 64'h8000_0000
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    // memory stage
    input  logic                       mem_jal_i,
    input  logic                       mem_branch_i,
    input  logic                       mem_jalr_i,
    input  logic                       trap_i,
    input  logic [fetch_pkg::XLEN-1:0] mem_alu_res_i,
    input  logic [fetch_pkg::XLEN-1:0] mem_pc_i,
    input  logic [fetch_pkg::XLEN-1:0] mem_imm_i,
    input  logic [fetch_pkg::XLEN-1:0] mem_rs1_i,
    input  logic [fetch_pkg::XLEN-1:0] mtvec_i,
    input  logic                       stall_i,
    // read channel
    output logic                       ar_valid_o,
    input  logic                       ar_ready_i,
    output logic [fetch_pkg::XLEN-1:0] ar_addr_o,
    input  logic                       r_valid_i,
    output logic                       r_ready_o,
    input  logic [fetch_pkg::XLEN-1:0] r_data_i,
    // decode
    output logic                       inst_valid_o,
    output logic [fetch_pkg::ILEN-1:0] inst_o,
    output logic [fetch_pkg::XLEN-1:0] pc_o,
    input  logic                       inst_ready_i
);
    import fetch_pkg::*;

    redirect_kind_e  redirect_kind;
    logic [XLEN-1:0] redirect_target;
    logic            req_valid;
    logic [XLEN-1:0] req_addr;
    logic            req_epoch;
    logic            bus_idle;
    logic            rsp_valid;
    logic [XLEN-1:0] rsp_data;
    logic            rsp_epoch;

    branch_resolver branch_resolver_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .mem_jal_i       (mem_jal_i),
        .mem_branch_i    (mem_branch_i),
        .mem_jalr_i      (mem_jalr_i),
        .trap_i          (trap_i),
        .mem_alu_res_i   (mem_alu_res_i),
        .mem_pc_i        (mem_pc_i),
        .mem_imm_i       (mem_imm_i),
        .mem_rs1_i       (mem_rs1_i),
        .mtvec_i         (mtvec_i),
        .redirect_kind   (redirect_kind),
        .redirect_target (redirect_target)
    );

    fetch_bus_master fetch_bus_master_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_epoch  (req_epoch),
        .bus_idle   (bus_idle),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .rsp_epoch  (rsp_epoch),
        .ar_valid_o (ar_valid_o),
        .ar_ready_i (ar_ready_i),
        .ar_addr_o  (ar_addr_o),
        .r_valid_i  (r_valid_i),
        .r_ready_o  (r_ready_o),
        .r_data_i   (r_data_i)
    );

    fetch_control #(
        .RESET_PC (RESET_PC)
    ) fetch_control_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .redirect_kind   (redirect_kind),
        .redirect_target (redirect_target),
        .bus_idle        (bus_idle),
        .rsp_valid       (rsp_valid),
        .rsp_epoch       (rsp_epoch),
        .rsp_data        (rsp_data),
        .req_valid       (req_valid),
        .req_addr        (req_addr),
        .req_epoch       (req_epoch),
        .stall_i         (stall_i),
        .inst_valid_o    (inst_valid_o),
        .inst_o          (inst_o),
        .pc_o            (pc_o),
        .inst_ready_i    (inst_ready_i)
    );

endmodule

/* sim/inst_mem_model.sv */
`timescale 1ns/10ps

module inst_mem_model #(
    parameter logic [31:0] INST_XOR = 32'h1357_9bdf
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       ar_valid_i,
    output logic                       ar_ready_o,
    input  logic [fetch_pkg::XLEN-1:0] ar_addr_i,
    output logic                       r_valid_o,
    input  logic                       r_ready_i,
    output logic [fetch_pkg::XLEN-1:0] r_data_o,
    input  logic                       ar_ready_en_i,
    input  logic                       r_valid_en_i
);
    import fetch_pkg::*;

    logic            pending_q;
    logic [XLEN-1:0] addr_q;

    // each 32-bit half holds its own byte address xor a constant
    function automatic logic [XLEN-1:0] word_at(input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] hi_addr;
        base    = {addr[XLEN-1:3], 3'b000};
        hi_addr = base + 64'd4;
        return {hi_addr[31:0] ^ INST_XOR, base[31:0] ^ INST_XOR};
    endfunction

    // address ready follows the random enable directly
    assign ar_ready_o = ar_ready_en_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
            r_valid_o <= 1'b0;
        end else begin
            if (ar_valid_i && ar_ready_o) begin
                pending_q <= 1'b1;
                addr_q    <= ar_addr_i;
            end
            // once raised, valid holds until the transfer
            if (r_valid_o && r_ready_i) begin
                r_valid_o <= 1'b0;
                pending_q <= 1'b0;
            end else if (pending_q && r_valid_en_i) begin
                r_valid_o <= 1'b1;
            end
        end
    end

    assign r_data_o = word_at(addr_q);

endmodule

/* sim/fetch_properties.sv */
`timescale 1ns/10ps

module fetch_properties (
    input logic                       clk,
    input logic                       rst_n_i,
    input logic                       stall_i,
    input logic                       ar_valid_i,
    input logic                       ar_ready_i,
    input logic [fetch_pkg::XLEN-1:0] ar_addr_i,
    input logic                       r_ready_i,
    input logic                       inst_valid_i,
    input logic                       inst_ready_i,
    input logic [fetch_pkg::ILEN-1:0] inst_i,
    input logic [fetch_pkg::XLEN-1:0] pc_i,
    input fetch_pkg::redirect_kind_e  redirect_kind_i
);
    import fetch_pkg::*;

    int unsigned error_count = 0;
    bus_state_e  bus_state;

    // bus master state seen from its handshake outputs
    assign bus_state = ar_valid_i ? st_addr : (r_ready_i ? st_data : st_idle);

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n_i |=> !ar_valid_i && !r_ready_i && !inst_valid_i)
        else begin
            $error("bus or decode valid high after a reset cycle");
            error_count++;
        end

    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
        else begin
            $error("address channel changed before ar_ready");
            error_count++;
        end

    // a redirect may kill the slot even under back-pressure
    a_inst_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        inst_valid_i && !inst_ready_i && (redirect_kind_i == rk_none)
        |=> inst_valid_i && $stable(inst_i) && $stable(pc_i))
        else begin
            $error("decode output changed while inst_ready was low");
            error_count++;
        end

    a_stall_no_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i && (bus_state == st_idle) |=> bus_state == st_idle)
        else begin
            $error("read started while stall was high");
            error_count++;
        end

endmodule

bind fetch_top fetch_properties fetch_properties_i (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .stall_i         (stall_i),
    .ar_valid_i      (ar_valid_o),
    .ar_ready_i      (ar_ready_i),
    .ar_addr_i       (ar_addr_o),
    .r_ready_i       (r_ready_o),
    .inst_valid_i    (inst_valid_o),
    .inst_ready_i    (inst_ready_i),
    .inst_i          (inst_o),
    .pc_i            (pc_o),
    .redirect_kind_i (redirect_kind)
);

/* sim/fetch_tb.sv */
`timescale 1ns/10ps

module fetch_tb;
    import fetch_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC   = 64'h8000_0000;
    localparam logic [31:0]     INST_XOR   = 32'h1357_9bdf;
    localparam int              MAX_CYCLES = 4000;

    logic            clk;
    logic            rst_n_i;
    logic            mem_jal_i;
    logic            mem_branch_i;
    logic            mem_jalr_i;
    logic            trap_i;
    logic [XLEN-1:0] mem_alu_res_i;
    logic [XLEN-1:0] mem_pc_i;
    logic [XLEN-1:0] mem_imm_i;
    logic [XLEN-1:0] mem_rs1_i;
    logic [XLEN-1:0] mtvec_i;
    logic            stall_i;
    logic            ar_valid_o;
    logic            ar_ready_i;
    logic [XLEN-1:0] ar_addr_o;
    logic            r_valid_i;
    logic            r_ready_o;
    logic [XLEN-1:0] r_data_i;
    logic            inst_valid_o;
    logic [ILEN-1:0] inst_o;
    logic [XLEN-1:0] pc_o;
    logic            inst_ready_i;
    logic            ar_ready_en;
    logic            r_valid_en;
    logic            hold_decode;
    logic [31:0]     lfsr;
    logic [XLEN-1:0] exp_pc;
    int              accepted;
    int              cycle_count = 0;

    fetch_top #(
        .RESET_PC (RESET_PC)
    ) fetch_top_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .mem_jal_i     (mem_jal_i),
        .mem_branch_i  (mem_branch_i),
        .mem_jalr_i    (mem_jalr_i),
        .trap_i        (trap_i),
        .mem_alu_res_i (mem_alu_res_i),
        .mem_pc_i      (mem_pc_i),
        .mem_imm_i     (mem_imm_i),
        .mem_rs1_i     (mem_rs1_i),
        .mtvec_i       (mtvec_i),
        .stall_i       (stall_i),
        .ar_valid_o    (ar_valid_o),
        .ar_ready_i    (ar_ready_i),
        .ar_addr_o     (ar_addr_o),
        .r_valid_i     (r_valid_i),
        .r_ready_o     (r_ready_o),
        .r_data_i      (r_data_i),
        .inst_valid_o  (inst_valid_o),
        .inst_o        (inst_o),
        .pc_o          (pc_o),
        .inst_ready_i  (inst_ready_i)
    );

    inst_mem_model #(
        .INST_XOR (INST_XOR)
    ) inst_mem_model_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .ar_valid_i    (ar_valid_o),
        .ar_ready_o    (ar_ready_i),
        .ar_addr_i     (ar_addr_o),
        .r_valid_o     (r_valid_i),
        .r_ready_i     (r_ready_o),
        .r_data_o      (r_data_i),
        .ar_ready_en_i (ar_ready_en),
        .r_valid_en_i  (r_valid_en)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic fail_and_stop();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            fail_and_stop();
        end
    end

    // one cycle of random delays, plus the check of any accepted instruction
    task automatic drive_cycle();
        logic [ILEN-1:0] exp_inst;
        @(negedge clk);
        lfsr        = lfsr_step(lfsr);
        ar_ready_en = lfsr[0];
        lfsr        = lfsr_step(lfsr);
        r_valid_en  = lfsr[0];
        lfsr        = lfsr_step(lfsr);
        inst_ready_i = hold_decode ? 1'b0 : lfsr[0];
        if (fetch_top_i.fetch_properties_i.error_count != 0) begin
            $display("a concurrent assertion failed, see the messages above");
            fail_and_stop();
        end
        if (inst_valid_o && inst_ready_i) begin
            exp_inst = exp_pc[31:0] ^ INST_XOR;
            assert (pc_o == exp_pc) else begin
                $display("[FAIL] %0t: pc_o %h, expected %h", $time, pc_o, exp_pc);
                fail_and_stop();
            end
            assert (inst_o == exp_inst) else begin
                $display("[FAIL] %0t: inst_o %h at pc %h, expected %h",
                         $time, inst_o, pc_o, exp_inst);
                fail_and_stop();
            end
            exp_pc   = exp_pc + 64'd4;
            accepted = accepted + 1;
        end
    endtask

    task automatic fetch_run(input int count);
        int target;
        target = accepted + count;
        while (accepted < target) begin
            drive_cycle();
        end
    endtask

    // pulse one set of memory-stage inputs, decode held off until the kill
    task automatic apply_redirect(input logic jal, input logic branch, input logic jalr,
                                  input logic trap, input logic [XLEN-1:0] alu,
                                  input logic [XLEN-1:0] pc, input logic [XLEN-1:0] imm,
                                  input logic [XLEN-1:0] rs1, input logic [XLEN-1:0] mtvec);
        logic [XLEN-1:0] sum;
        logic [XLEN-1:0] target;
        logic            taken;
        sum    = rs1 + imm;
        taken  = 1'b1;
        target = '0;
        if (jal || (branch && alu == '0)) begin
            target = pc + imm;
        end else if (jalr) begin
            target = {sum[XLEN-1:1], 1'b0};
        end else if (trap) begin
            target = mtvec;
        end else begin
            taken = 1'b0;
        end
        mem_jal_i     = jal;
        mem_branch_i  = branch;
        mem_jalr_i    = jalr;
        trap_i        = trap;
        mem_alu_res_i = alu;
        mem_pc_i      = pc;
        mem_imm_i     = imm;
        mem_rs1_i     = rs1;
        mtvec_i       = mtvec;
        hold_decode   = 1'b1;
        drive_cycle();
        mem_jal_i    = 1'b0;
        mem_branch_i = 1'b0;
        mem_jalr_i   = 1'b0;
        trap_i       = 1'b0;
        drive_cycle();
        drive_cycle();
        if (taken) begin
            exp_pc = target;
        end
        hold_decode = 1'b0;
    endtask

    initial begin
        rst_n_i       = 1'b0;
        mem_jal_i     = 1'b0;
        mem_branch_i  = 1'b0;
        mem_jalr_i    = 1'b0;
        trap_i        = 1'b0;
        mem_alu_res_i = '0;
        mem_pc_i      = '0;
        mem_imm_i     = '0;
        mem_rs1_i     = '0;
        mtvec_i       = '0;
        stall_i       = 1'b0;
        inst_ready_i  = 1'b0;
        ar_ready_en   = 1'b0;
        r_valid_en    = 1'b0;
        hold_decode   = 1'b0;
        lfsr          = 32'hb115;
        exp_pc        = RESET_PC;
        accepted      = 0;
        repeat (16) @(negedge clk);
        rst_n_i = 1'b1;

        fetch_run(50);
        apply_redirect(1'b1, 1'b0, 1'b0, 1'b0, 64'd0, 64'h8000_0100, 64'h400, 64'd0, 64'd0);
        fetch_run(50);
        apply_redirect(1'b0, 1'b1, 1'b0, 1'b0, 64'd0, 64'h8000_1000, 64'h24, 64'd0, 64'd0);
        fetch_run(50);
        // branch compare not zero, so the stream must continue
        apply_redirect(1'b0, 1'b1, 1'b0, 1'b0, 64'd5, 64'h8000_1800, 64'h80, 64'd0, 64'd0);
        fetch_run(50);
        apply_redirect(1'b0, 1'b0, 1'b1, 1'b0, 64'd0, 64'd0, 64'h104, 64'h8000_2001, 64'd0);
        fetch_run(50);
        apply_redirect(1'b0, 1'b0, 1'b0, 1'b1, 64'd0, 64'd0, 64'd0, 64'd0, 64'h8000_3000);
        stall_i = 1'b1;
        repeat (30) drive_cycle();
        stall_i = 1'b0;
        fetch_run(50);
        repeat (4) drive_cycle();

        if (fetch_top_i.fetch_properties_i.error_count != 0) begin
            $display("a concurrent assertion failed, see the messages above");
            fail_and_stop();
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

/* build.f */
hw/fetch_pkg.sv
hw/branch_resolver.sv
hw/fetch_bus_master.sv
hw/fetch_control.sv
hw/fetch_top.sv
sim/inst_mem_model.sv
sim/fetch_properties.sv
sim/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module fetch_tb \
    -f build.f \
    -Mdir obj_dir \
    -o fetch_sim

# the simulation may stop with a nonzero status; the log decides
./obj_dir/fetch_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "^PASS: all tests$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
